/* Bender.yml */
package:
  name: ifetch

sources:
  - files:
      - source/ifetch_pkg.sv
      - source/icache_sram.sv
      - source/itlb.sv
      - source/ifetch_tag_stage.sv
      - source/ifetch_data_stage.sv
      - source/ifetch_top.sv
  - target: simulation
    files:
      - testbench/ifetch_tb.sv

/* ifetch.f */
source/ifetch_pkg.sv
source/icache_sram.sv
source/itlb.sv
source/ifetch_tag_stage.sv
source/ifetch_data_stage.sv
source/ifetch_top.sv
testbench/ifetch_tb.sv

/* source/icache_sram.sv */
// Instruction cache line array
// One read port and one write port, registered read,
// a read of the line being written returns the new data
`timescale 1ns/10ps
`default_nettype none

module icache_sram
    import ifetch_pkg::*;
(
    input wire clk,
    input wire read_en,
    input wire [LINE_INDEX_BITS-1:0] read_addr,
    output line_data_t read_data,
    input wire data_update_t write
);

    line_data_t lines [NUM_WAYS * NUM_SETS];
    logic [LINE_INDEX_BITS-1:0] write_addr;

    // Way in the high bit, set below it
    assign write_addr = {write.way, write.set_idx};

    always_ff @(posedge clk)
    begin
        if (write.en)
            lines[write_addr] <= write.data;

        if (read_en)
        begin
            if (write.en && write_addr == read_addr)
                read_data <= write.data;
            else
                read_data <= lines[read_addr];
        end
    end

endmodule

`default_nettype wire

/* source/ifetch_data_stage.sv */
// Fetch data stage
// Hit and near-miss detection, miss request, line read,
// word extraction and fault generation
`timescale 1ns/10ps
`default_nettype none

module ifetch_data_stage
    import ifetch_pkg::*;
(
    input wire clk,
    input wire reset,
    input wire tag_result_t tag_in,
    input wire fill_tag_en,
    input wire set_idx_t fill_set,
    input wire tag_t fill_tag,
    input wire rollback_en,
    input wire thread_idx_t rollback_thread,
    input wire [NUM_THREADS-1:0] supervisor_en,
    output logic sram_read_en,
    output logic [LINE_INDEX_BITS-1:0] sram_read_addr,
    input wire line_data_t sram_read_data,
    output logic lru_update_en,
    output way_idx_t lru_update_way,
    output logic near_miss,
    output miss_req_t miss_req,
    output fetch_result_t fetch_out
);

    logic [NUM_WAYS-1:0] way_hit;
    way_idx_t hit_way;
    logic cache_hit;
    logic rollback_here;
    logic live;
    logic tlb_ok;
    logic [LINE_OFFSET_BITS-3:0] lane;
    logic [31:0] word;
    logic valid_q;
    logic tlb_miss_q;
    logic page_fault_q;
    logic executable_fault_q;
    logic supervisor_fault_q;
    logic alignment_fault_q;
    logic [31:0] pc_q;
    thread_idx_t thread_q;

    always_comb
    begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            way_hit[w] = tag_in.way_valid[w] && tag_in.way_tag[w] == tag_in.paddr.f.tag;
            if (way_hit[w])
                hit_way = way_idx_t'(w);
        end
    end

    assign tlb_ok = tag_in.requested && tag_in.tlb_hit;
    assign cache_hit = |way_hit && tag_in.tlb_hit;
    assign rollback_here = rollback_en && rollback_thread == tag_in.thread;
    assign live = tag_in.requested && !rollback_here;

    // Line is being tagged right now, its data lands next cycle, so retry
    assign near_miss = !cache_hit && tlb_ok && fill_tag_en
        && fill_set == tag_in.paddr.f.set_idx && fill_tag == tag_in.paddr.f.tag;

    assign miss_req.valid = !cache_hit && tlb_ok && !near_miss && !rollback_here;
    assign miss_req.line_addr = {tag_in.paddr.f.tag, tag_in.paddr.f.set_idx};
    assign miss_req.thread = tag_in.thread;

    assign sram_read_en = cache_hit && tag_in.requested;
    assign sram_read_addr = {hit_way, tag_in.paddr.f.set_idx};
    assign lru_update_en = cache_hit && tag_in.requested;
    assign lru_update_way = hit_way;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            valid_q <= 1'b0;
            tlb_miss_q <= 1'b0;
            page_fault_q <= 1'b0;
            executable_fault_q <= 1'b0;
            supervisor_fault_q <= 1'b0;
            alignment_fault_q <= 1'b0;
        end
        else
        begin
            // TLB miss hides the entry flags, a missing page hides the rest
            valid_q <= live && cache_hit;
            tlb_miss_q <= live && !tag_in.tlb_hit;
            page_fault_q <= live && tag_in.tlb_hit && !tag_in.tlb_present;
            executable_fault_q <= live && tag_in.tlb_hit && tag_in.tlb_present
                && !tag_in.tlb_executable;
            supervisor_fault_q <= live && tag_in.tlb_hit && tag_in.tlb_present
                && tag_in.tlb_supervisor && !supervisor_en[tag_in.thread];
            alignment_fault_q <= live && tag_in.vaddr[1:0] != 2'b00;
        end
    end

    always_ff @(posedge clk)
    begin
        pc_q <= tag_in.vaddr;
        thread_q <= tag_in.thread;
    end

    // Offset 0 sits in the top lane of the line
    assign lane = ~pc_q[LINE_OFFSET_BITS-1:2];
    assign word = sram_read_data[32 * lane +: 32];

    always_comb
    begin
        fetch_out.instruction_valid = valid_q;
        fetch_out.instruction = {word[7:0], word[15:8], word[23:16], word[31:24]};
        fetch_out.pc = pc_q;
        fetch_out.thread = thread_q;
        fetch_out.tlb_miss = tlb_miss_q;
        fetch_out.page_fault = page_fault_q;
        fetch_out.executable_fault = executable_fault_q;
        fetch_out.supervisor_fault = supervisor_fault_q;
        fetch_out.alignment_fault = alignment_fault_q;
    end

    // Tag stage must never leave one line in two ways
    assert property (@(posedge clk) disable iff (reset)
        tag_in.requested |-> $onehot0(way_hit));

    assert property (@(posedge clk) disable iff (reset)
        fetch_out.tlb_miss |-> !(fetch_out.page_fault || fetch_out.executable_fault
        || fetch_out.supervisor_fault || fetch_out.instruction_valid));

    assert property (@(posedge clk) disable iff (reset)
        fetch_out.page_fault |-> !(fetch_out.executable_fault || fetch_out.supervisor_fault));

endmodule

`default_nettype wire

/* source/ifetch_pkg.sv */
// Shared sizes and types for the instruction fetch front end
// Cache geometry, address views, TLB entries and stage-to-stage structs
`default_nettype none

package ifetch_pkg;

    localparam int NUM_THREADS = 4;
    localparam int NUM_WAYS = 2;
    localparam int NUM_SETS = 32;
    localparam int LINE_BYTES = 64;
    localparam int LINE_BITS = LINE_BYTES * 8;
    localparam int LINE_OFFSET_BITS = $clog2(LINE_BYTES);
    localparam int SET_BITS = $clog2(NUM_SETS);
    localparam int TAG_BITS = 32 - SET_BITS - LINE_OFFSET_BITS;
    localparam int LINE_INDEX_BITS = $clog2(NUM_WAYS * NUM_SETS);
    localparam int PAGE_BITS = 12;
    localparam int VPAGE_BITS = 32 - PAGE_BITS;
    localparam int TLB_ENTRIES = 16;
    localparam int TLB_INDEX_BITS = $clog2(TLB_ENTRIES);
    localparam int TLB_TAG_BITS = VPAGE_BITS - TLB_INDEX_BITS;

    typedef logic [$clog2(NUM_THREADS)-1:0] thread_idx_t;
    typedef logic [$clog2(NUM_WAYS)-1:0] way_idx_t;
    typedef logic [SET_BITS-1:0] set_idx_t;
    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [LINE_OFFSET_BITS-1:0] line_offset_t;
    typedef logic [LINE_BITS-1:0] line_data_t;
    typedef logic [TAG_BITS+SET_BITS-1:0] line_addr_t;
    typedef logic [VPAGE_BITS-1:0] vpage_t;

    typedef struct packed {
        tag_t tag;
        set_idx_t set_idx;
        line_offset_t offset;
    } paddr_fields_t;

    // Physical address, built as a word and read back as cache fields
    typedef union packed {
        logic [31:0] raw;
        paddr_fields_t f;
    } paddr_t;

    typedef struct packed {
        logic [VPAGE_BITS-1:0] ppage;
        logic present;
        logic executable;
        logic supervisor;
    } tlb_entry_t;

    typedef struct packed {
        logic en;
        vpage_t vpage;
        tlb_entry_t entry;
    } tlb_update_t;

    typedef struct packed {
        logic requested;
        thread_idx_t thread;
        logic [31:0] vaddr;
        paddr_t paddr;
        logic tlb_hit;
        logic tlb_present;
        logic tlb_executable;
        logic tlb_supervisor;
        tag_t [NUM_WAYS-1:0] way_tag;
        logic [NUM_WAYS-1:0] way_valid;
    } tag_result_t;

    typedef struct packed {
        logic en;
        set_idx_t set_idx;
        tag_t tag;
        line_data_t data;
    } fill_t;

    typedef struct packed {
        logic en;
        way_idx_t way;
        set_idx_t set_idx;
        line_data_t data;
    } data_update_t;

    typedef struct packed {
        logic valid;
        line_addr_t line_addr;
        thread_idx_t thread;
    } miss_req_t;

    typedef struct packed {
        logic instruction_valid;
        logic [31:0] instruction;
        logic [31:0] pc;
        thread_idx_t thread;
        logic tlb_miss;
        logic page_fault;
        logic executable_fault;
        logic supervisor_fault;
        logic alignment_fault;
    } fetch_result_t;

endpackage

`default_nettype wire

/* source/ifetch_tag_stage.sv */
// Fetch tag stage
// Per-thread PCs and sleep state, round-robin thread pick,
// TLB lookup, tag/valid/LRU arrays and line fill sequencing
`timescale 1ns/10ps
`default_nettype none

module ifetch_tag_stage
    import ifetch_pkg::*;
(
    input wire clk,
    input wire reset,
    input wire redirect_en,
    input wire thread_idx_t redirect_thread,
    input wire [31:0] redirect_pc,
    input wire [NUM_THREADS-1:0] thread_en,
    input wire fill_t fill,
    input wire miss_strobe,
    input wire thread_idx_t miss_thread,
    input wire near_miss,
    input wire lru_update_en,
    input wire way_idx_t lru_update_way,
    output vpage_t tlb_vpage,
    input wire tlb_hit,
    input wire tlb_entry_t tlb_entry,
    output tag_result_t tag_out,
    output data_update_t data_update
);

    logic [31:0] pc [NUM_THREADS];
    logic [NUM_THREADS-1:0] ready;
    logic [NUM_THREADS-1:0] waiting;
    line_addr_t wait_line [NUM_THREADS];
    thread_idx_t last_thread;
    logic [NUM_THREADS-1:0] can_run;
    logic sel_valid;
    thread_idx_t sel_thread;
    logic [31:0] sel_pc;
    paddr_t lookup_paddr;
    set_idx_t lookup_set;
    logic retry;
    tag_t tags [NUM_WAYS][NUM_SETS];
    logic [NUM_WAYS-1:0][NUM_SETS-1:0] valid_bits;
    logic [NUM_SETS-1:0] lru_bits;
    way_idx_t fill_way;
    line_addr_t fill_line;
    tag_result_t tag_next;
    tag_result_t tag_q;
    logic tag_requested;
    data_update_t update_q;
    logic update_en;

    assign retry = near_miss || miss_strobe;
    assign fill_line = {fill.tag, fill.set_idx};

    // A thread being redirected or retried must not issue its stale PC
    always_comb
    begin
        can_run = ready & ~waiting & thread_en;
        if (redirect_en)
            can_run[redirect_thread] = 1'b0;
        if (retry)
            can_run[tag_out.thread] = 1'b0;
    end

    // Round robin, starting after the last thread picked
    always_comb
    begin
        thread_idx_t cand;
        sel_valid = 1'b0;
        sel_thread = last_thread;
        for (int i = 1; i <= NUM_THREADS; i++)
        begin
            cand = thread_idx_t'(last_thread + i);
            if (!sel_valid && can_run[cand])
            begin
                sel_valid = 1'b1;
                sel_thread = cand;
            end
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            ready <= '0;
            waiting <= '0;
            last_thread <= '0;
            for (int t = 0; t < NUM_THREADS; t++)
            begin
                pc[t] <= '0;
                wait_line[t] <= '0;
            end
        end
        else
        begin
            if (sel_valid)
                last_thread <= sel_thread;
            for (int t = 0; t < NUM_THREADS; t++)
            begin
                if (redirect_en && redirect_thread == thread_idx_t'(t))
                begin
                    pc[t] <= redirect_pc;
                    ready[t] <= 1'b1;
                    waiting[t] <= 1'b0;
                end
                else if (miss_strobe && miss_thread == thread_idx_t'(t))
                begin
                    // Sleep until the missing line is tagged
                    pc[t] <= tag_out.vaddr;
                    ready[t] <= 1'b0;
                    waiting[t] <= 1'b1;
                    wait_line[t] <= {tag_out.paddr.f.tag, tag_out.paddr.f.set_idx};
                end
                else if (near_miss && tag_out.thread == thread_idx_t'(t))
                    pc[t] <= tag_out.vaddr;
                else if (waiting[t] && fill.en && wait_line[t] == fill_line)
                begin
                    waiting[t] <= 1'b0;
                    ready[t] <= 1'b1;
                end
                else if (sel_valid && sel_thread == thread_idx_t'(t))
                    pc[t] <= pc[t] + 32'd4;
            end
        end
    end

    // Refill a way that already holds the line, otherwise the LRU way
    always_comb
    begin
        fill_way = lru_bits[fill.set_idx];
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            if (valid_bits[w][fill.set_idx] && tags[w][fill.set_idx] == fill.tag)
                fill_way = way_idx_t'(w);
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill.en)
            tags[fill_way][fill.set_idx] <= fill.tag;
    end

    // LRU bit names the way to evict next; a fill makes its way most recent
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            valid_bits <= '0;
            lru_bits <= '0;
        end
        else
        begin
            if (lru_update_en)
                lru_bits[tag_out.paddr.f.set_idx] <= ~lru_update_way;
            if (fill.en)
            begin
                valid_bits[fill_way][fill.set_idx] <= 1'b1;
                lru_bits[fill.set_idx] <= ~fill_way;
            end
        end
    end

    assign sel_pc = pc[sel_thread];
    assign tlb_vpage = sel_pc[31:PAGE_BITS];
    assign lookup_paddr.raw = {tlb_entry.ppage, sel_pc[PAGE_BITS-1:0]};
    assign lookup_set = lookup_paddr.f.set_idx;

    always_comb
    begin
        tag_next.requested = sel_valid;
        tag_next.thread = sel_thread;
        tag_next.vaddr = sel_pc;
        tag_next.paddr = lookup_paddr;
        tag_next.tlb_hit = tlb_hit;
        tag_next.tlb_present = tlb_entry.present;
        tag_next.tlb_executable = tlb_entry.executable;
        tag_next.tlb_supervisor = tlb_entry.supervisor;
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            tag_next.way_tag[w] = tags[w][lookup_set];
            tag_next.way_valid[w] = valid_bits[w][lookup_set];
            // Forward a tag written this cycle into the looked-up set
            if (fill.en && fill_way == way_idx_t'(w) && fill.set_idx == lookup_set)
            begin
                tag_next.way_tag[w] = fill.tag;
                tag_next.way_valid[w] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            tag_requested <= 1'b0;
            update_en <= 1'b0;
        end
        else
        begin
            tag_requested <= sel_valid;
            update_en <= fill.en;
        end
    end

    // Line data trails its tag write by one cycle
    always_ff @(posedge clk)
    begin
        tag_q <= tag_next;
        update_q <= '{en: fill.en, way: fill_way, set_idx: fill.set_idx, data: fill.data};
    end

    always_comb
    begin
        tag_out = tag_q;
        tag_out.requested = tag_requested;
        data_update = update_q;
        data_update.en = update_en;
    end

    // A thread is never runnable while asleep on a line
    assert property (@(posedge clk) disable iff (reset) (ready & waiting) == '0);

endmodule

`default_nettype wire

/* source/ifetch_top.sv */
// Instruction fetch front end top level
// Tag stage, TLB, data stage and the line array
`timescale 1ns/10ps
`default_nettype none

module ifetch_top
    import ifetch_pkg::*;
(
    input wire clk,
    input wire reset,
    input wire redirect_en,
    input wire thread_idx_t redirect_thread,
    input wire [31:0] redirect_pc,
    input wire rollback_en,
    input wire thread_idx_t rollback_thread,
    input wire [NUM_THREADS-1:0] thread_en,
    input wire [NUM_THREADS-1:0] supervisor_en,
    input wire tlb_update_t tlb_update,
    input wire fill_t fill,
    output miss_req_t miss_req,
    output fetch_result_t fetch_out
);

    tag_result_t tag_result;
    data_update_t data_update;
    vpage_t tlb_vpage;
    logic tlb_hit;
    tlb_entry_t tlb_entry;
    logic lru_update_en;
    way_idx_t lru_update_way;
    logic near_miss;
    logic sram_read_en;
    logic [LINE_INDEX_BITS-1:0] sram_read_addr;
    line_data_t sram_read_data;

    ifetch_tag_stage ifetch_tag_stage_i (
        .clk(clk),
        .reset(reset),
        .redirect_en(redirect_en),
        .redirect_thread(redirect_thread),
        .redirect_pc(redirect_pc),
        .thread_en(thread_en),
        .fill(fill),
        .miss_strobe(miss_req.valid),
        .miss_thread(miss_req.thread),
        .near_miss(near_miss),
        .lru_update_en(lru_update_en),
        .lru_update_way(lru_update_way),
        .tlb_vpage(tlb_vpage),
        .tlb_hit(tlb_hit),
        .tlb_entry(tlb_entry),
        .tag_out(tag_result),
        .data_update(data_update)
    );

    itlb itlb_i (
        .clk(clk),
        .reset(reset),
        .update(tlb_update),
        .lookup_vpage(tlb_vpage),
        .hit(tlb_hit),
        .entry(tlb_entry)
    );

    ifetch_data_stage ifetch_data_stage_i (
        .clk(clk),
        .reset(reset),
        .tag_in(tag_result),
        .fill_tag_en(fill.en),
        .fill_set(fill.set_idx),
        .fill_tag(fill.tag),
        .rollback_en(rollback_en),
        .rollback_thread(rollback_thread),
        .supervisor_en(supervisor_en),
        .sram_read_en(sram_read_en),
        .sram_read_addr(sram_read_addr),
        .sram_read_data(sram_read_data),
        .lru_update_en(lru_update_en),
        .lru_update_way(lru_update_way),
        .near_miss(near_miss),
        .miss_req(miss_req),
        .fetch_out(fetch_out)
    );

    icache_sram icache_sram_i (
        .clk(clk),
        .read_en(sram_read_en),
        .read_addr(sram_read_addr),
        .read_data(sram_read_data),
        .write(data_update)
    );

endmodule

`default_nettype wire

/* source/itlb.sv */
// Instruction TLB
// Direct-mapped table indexed by the low page bits,
// combinational lookup and a single write port
`timescale 1ns/10ps
`default_nettype none

module itlb
    import ifetch_pkg::*;
(
    input wire clk,
    input wire reset,
    input wire tlb_update_t update,
    input wire vpage_t lookup_vpage,
    output logic hit,
    output tlb_entry_t entry
);

    logic [TLB_ENTRIES-1:0] entry_valid;
    logic [TLB_TAG_BITS-1:0] entry_tag [TLB_ENTRIES];
    tlb_entry_t entry_data [TLB_ENTRIES];
    logic [TLB_INDEX_BITS-1:0] lookup_idx;
    logic [TLB_INDEX_BITS-1:0] update_idx;

    assign lookup_idx = lookup_vpage[TLB_INDEX_BITS-1:0];
    assign update_idx = update.vpage[TLB_INDEX_BITS-1:0];

    // Valid bits only, the stored pages are don't-care until written
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            entry_valid <= '0;
        end
        else if (update.en)
        begin
            entry_valid[update_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (update.en)
        begin
            entry_tag[update_idx] <= update.vpage[VPAGE_BITS-1:TLB_INDEX_BITS];
            entry_data[update_idx] <= update.entry;
        end
    end

    // Read from flops, so a write shows up on the following cycle
    assign hit = entry_valid[lookup_idx]
        && entry_tag[lookup_idx] == lookup_vpage[VPAGE_BITS-1:TLB_INDEX_BITS];
    assign entry = entry_data[lookup_idx];

endmodule

`default_nettype wire

/* testbench/ifetch_tb.sv */
// Testbench for the instruction fetch front end
// Clock and reset, L2 memory model answering misses with line fills,
// stream, LRU, fault, rollback and thread enable tests
`timescale 1ns/10ps
`default_nettype none

module ifetch_tb
    import ifetch_pkg::*;
();

    logic clk;
    logic reset;
    logic redirect_en;
    thread_idx_t redirect_thread;
    logic [31:0] redirect_pc;
    logic rollback_en;
    thread_idx_t rollback_thread;
    logic [NUM_THREADS-1:0] thread_en;
    logic [NUM_THREADS-1:0] supervisor_en;
    tlb_update_t tlb_update;
    fill_t fill;
    miss_req_t miss_req;
    fetch_result_t fetch_out;

    logic [7:0] mem [65536];
    logic [31:0] rnd_state;
    logic [19:0] page_map [logic [19:0]];
    line_addr_t pending_line [$];
    int pending_due [$];
    int cycle = 0;
    logic [31:0] exp_pc [NUM_THREADS];
    int delivered [NUM_THREADS] = '{default: 0};
    int off_cycles [NUM_THREADS] = '{default: 0};
    logic fresh [NUM_THREADS] = '{default: 1'b0};
    logic [31:0] first_pc [NUM_THREADS];
    int miss_count = 0;
    logic fault_seen = 1'b0;
    logic [4:0] fault_bits;

    ifetch_top ifetch_top_i (
        .clk(clk),
        .reset(reset),
        .redirect_en(redirect_en),
        .redirect_thread(redirect_thread),
        .redirect_pc(redirect_pc),
        .rollback_en(rollback_en),
        .rollback_thread(rollback_thread),
        .thread_en(thread_en),
        .supervisor_en(supervisor_en),
        .tlb_update(tlb_update),
        .fill(fill),
        .miss_req(miss_req),
        .fetch_out(fetch_out)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk)
        cycle = cycle + 1;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Memory word in big-endian byte order
    function automatic logic [31:0] expected_word(input logic [31:0] paddr);
        logic [15:0] a;
        a = paddr[15:0];
        return {mem[a], mem[a + 16'd1], mem[a + 16'd2], mem[a + 16'd3]};
    endfunction

    function automatic logic [31:0] translate(input logic [31:0] vaddr);
        if (page_map.exists(vaddr[31:12]))
            return {page_map[vaddr[31:12]], vaddr[11:0]};
        return vaddr;
    endfunction

    // Word k sits k lanes below the top, low byte first
    function automatic line_data_t line_image(input line_addr_t line);
        line_data_t data;
        logic [15:0] base;
        for (int k = 0; k < 16; k++)
        begin
            base = 16'({line, 6'b0}) + 16'(4 * k);
            data[32 * (15 - k) +: 32] =
                {mem[base + 16'd3], mem[base + 16'd2], mem[base + 16'd1], mem[base]};
        end
        return data;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual)
            report_failure($sformatf("** Error: %s expected %0h actual %0h",
                name, expected, actual));
    endtask

    // L2 model collects misses
    always @(negedge clk)
    begin
        if (!reset && miss_req.valid)
        begin
            rnd_state = lcg_next(rnd_state);
            pending_line.push_back(miss_req.line_addr);
            pending_due.push_back(cycle + 3 + int'(rnd_state[18:16]));
        end
    end

    // One fill per cycle, first request whose delay has run out
    initial
    begin
        int pick;
        fill = '0;
        forever
        begin
            @(posedge clk);
            #1;
            pick = -1;
            for (int i = 0; i < pending_line.size(); i++)
            begin
                if (pick < 0 && pending_due[i] <= cycle)
                    pick = i;
            end
            if (pick >= 0)
            begin
                fill.en = 1'b1;
                fill.set_idx = pending_line[pick][SET_BITS-1:0];
                fill.tag = pending_line[pick][SET_BITS +: TAG_BITS];
                fill.data = line_image(pending_line[pick]);
                pending_line.delete(pick);
                pending_due.delete(pick);
            end
            else
                fill.en = 1'b0;
        end
    end

    // Compare outputs against the per-thread expected streams
    always @(negedge clk)
    begin
        logic [4:0] faults;
        logic [31:0] paddr;
        int t;
        if (!reset)
        begin
            for (int i = 0; i < NUM_THREADS; i++)
                off_cycles[i] = thread_en[i] ? 0 : off_cycles[i] + 1;
            faults = {fetch_out.tlb_miss, fetch_out.page_fault, fetch_out.executable_fault,
                fetch_out.supervisor_fault, fetch_out.alignment_fault};
            t = int'(fetch_out.thread);
            if ((fetch_out.instruction_valid || faults != '0) && off_cycles[t] > 2)
                report_failure($sformatf("Thread %0d fetched %0d cycles after it was disabled",
                    t, off_cycles[t]));
            if (fetch_out.instruction_valid)
            begin
                check_value($sformatf("thread %0d pc", t), exp_pc[t], fetch_out.pc);
                if (!fetch_out.alignment_fault)
                    check_value($sformatf("thread %0d word at %0h", t, fetch_out.pc),
                        expected_word(translate(fetch_out.pc)), fetch_out.instruction);
                if (fresh[t])
                    first_pc[t] = fetch_out.pc;
                fresh[t] = 1'b0;
                exp_pc[t] = exp_pc[t] + 32'd4;
                delivered[t]++;
            end
            if (faults != '0 && t == 1 && !fault_seen)
            begin
                fault_seen = 1'b1;
                fault_bits = faults;
            end
            if (miss_req.valid)
            begin
                miss_count++;
                paddr = translate(exp_pc[miss_req.thread]);
                check_value($sformatf("thread %0d miss line", miss_req.thread),
                    paddr[31:6], miss_req.line_addr);
            end
            if (redirect_en)
            begin
                exp_pc[redirect_thread] = redirect_pc;
                fresh[redirect_thread] = 1'b1;
            end
        end
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // Let the pipeline empty and every outstanding fill arrive
    task automatic drain();
        int waited;
        repeat (3) step();
        waited = 0;
        while (pending_line.size() != 0 && waited < 200)
        begin
            step();
            waited++;
        end
        if (pending_line.size() != 0)
            report_failure("Timeout: outstanding line fills never arrived");
        repeat (3) step();
    endtask

    task automatic write_tlb(input vpage_t vpage, input logic [19:0] ppage,
                             input logic present, input logic executable,
                             input logic supervisor);
        tlb_update.en = 1'b1;
        tlb_update.vpage = vpage;
        tlb_update.entry.ppage = ppage;
        tlb_update.entry.present = present;
        tlb_update.entry.executable = executable;
        tlb_update.entry.supervisor = supervisor;
        page_map[vpage] = ppage;
        step();
        tlb_update.en = 1'b0;
    endtask

    // Redirect with rollback, as the downstream stage would send it
    task automatic start_thread(input int t, input logic [31:0] pc);
        redirect_en = 1'b1;
        redirect_thread = thread_idx_t'(t);
        redirect_pc = pc;
        rollback_en = 1'b1;
        rollback_thread = thread_idx_t'(t);
        thread_en[t] = 1'b1;
        step();
        redirect_en = 1'b0;
        rollback_en = 1'b0;
    endtask

    task automatic wait_words(input int t, input int n);
        int start;
        int waited;
        start = delivered[t];
        waited = 0;
        while (delivered[t] - start < n && waited < 200 + 40 * n)
        begin
            step();
            waited++;
        end
        if (delivered[t] - start < n)
            report_failure($sformatf("Timeout: thread %0d delivered only %0d of %0d words",
                t, delivered[t] - start, n));
    endtask

    task automatic run_words(input int t, input logic [31:0] pc, input int n);
        start_thread(t, pc);
        wait_words(t, n);
        thread_en[t] = 1'b0;
        drain();
    endtask

    task automatic fault_case(input string name, input logic [31:0] pc,
                              input logic [4:0] expected);
        int waited;
        fault_seen = 1'b0;
        start_thread(1, pc);
        waited = 0;
        while (!fault_seen && waited < 300)
        begin
            step();
            waited++;
        end
        if (!fault_seen)
            report_failure($sformatf("Timeout: no fault seen in test %s", name));
        thread_en[1] = 1'b0;
        drain();
        check_value(name, 64'(expected), 64'(fault_bits));
    endtask

    initial
    begin
        int misses_before;
        int quiet_count;
        reset = 1'b1;
        redirect_en = 1'b0;
        redirect_thread = '0;
        redirect_pc = '0;
        rollback_en = 1'b0;
        rollback_thread = '0;
        thread_en = '0;
        supervisor_en = 4'b1101;
        tlb_update = '0;
        rnd_state = 32'h7d207267;
        for (int i = 0; i < 65536; i += 4)
        begin
            rnd_state = lcg_next(rnd_state);
            {mem[i], mem[i + 1], mem[i + 2], mem[i + 3]} = rnd_state;
        end
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        step();
        for (int p = 0; p < 16; p++)
            write_tlb(vpage_t'(p), 20'(p), 1'b1, 1'b1, 1'b0);

        // Single thread across several line misses
        run_words(0, 32'h0000_0100, 160);

        // Four threads at scattered PCs
        start_thread(0, 32'h0000_1040);
        start_thread(1, 32'h0000_2a84);
        start_thread(2, 32'h0000_5300);
        start_thread(3, 32'h0000_9f08);
        for (int t = 0; t < NUM_THREADS; t++)
            wait_words(t, 64);
        thread_en = '0;
        drain();

        // Three lines in one set, LRU keeps the line used last
        run_words(0, 32'h0000_c600, 4);
        run_words(0, 32'h0000_ce00, 4);
        run_words(0, 32'h0000_c600, 4);
        run_words(0, 32'h0000_d600, 4);
        misses_before = miss_count;
        run_words(0, 32'h0000_c600, 4);
        check_value("lru keeps recent line", 0, miss_count - misses_before);
        misses_before = miss_count;
        run_words(0, 32'h0000_ce00, 4);
        check_value("evicted line misses again", 1, miss_count - misses_before);

        // Fault order is tlb_miss, page, executable, supervisor, alignment
        fault_case("tlb miss", 32'h0003_0000, 5'b10000);
        write_tlb(20'h00021, 20'h00001, 1'b0, 1'b0, 1'b1);
        fault_case("page fault", 32'h0002_1000, 5'b01000);
        write_tlb(20'h00022, 20'h00002, 1'b1, 1'b0, 1'b0);
        fault_case("executable fault", 32'h0002_2000, 5'b00100);
        write_tlb(20'h00023, 20'h00003, 1'b1, 1'b1, 1'b1);
        fault_case("supervisor fault", 32'h0002_3000, 5'b00010);
        fault_case("alignment fault", 32'h0000_8002, 5'b00001);
        for (int p = 1; p < 4; p++)
            write_tlb(vpage_t'(p), 20'(p), 1'b1, 1'b1, 1'b0);

        // Rollback with redirect while two threads run
        start_thread(0, 32'h0000_4000);
        start_thread(2, 32'h0000_6000);
        wait_words(0, 20);
        start_thread(0, 32'h0000_7100);
        wait_words(0, 20);
        check_value("first pc after rollback", 32'h0000_7100, first_pc[0]);
        wait_words(2, 20);
        thread_en = '0;
        drain();

        // Dropping one thread enable leaves the others running
        start_thread(0, 32'h0000_a000);
        start_thread(1, 32'h0000_b040);
        start_thread(2, 32'h0000_e080);
        start_thread(3, 32'h0000_f0c0);
        for (int t = 0; t < NUM_THREADS; t++)
            wait_words(t, 16);
        thread_en[2] = 1'b0;
        repeat (3) step();
        quiet_count = delivered[2];
        wait_words(0, 24);
        wait_words(1, 24);
        wait_words(3, 24);
        check_value("disabled thread stays quiet", quiet_count, delivered[2]);
        thread_en = '0;
        drain();

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire
